//--- files.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_req_if.sv
hdl/mem_attr_lookup.sv
hdl/write_buffer.sv
hdl/bus_arbiter.sv
hdl/sram_slave.sv
hdl/mem_subsys_top.sv
tests/mem_subsys_props.sv
tests/mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module mem_subsys_tb \
  -f files.f \
  -o mem_subsys_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/mem_subsys_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
fi

if grep -q "All tests passed!" "$LOG"; then
  exit 0
fi
echo "Simulation did not pass"
exit 1

//--- tests/mem_subsys_tb.sv
// Testbench for the data-memory subsystem
// Random requests on both ports, word model per port half, read data checks

`include "mem_cfg.svh"

module mem_subsys_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int SLOTS = 16;
  // Requests per phase, prefill then B idle then B busy
  localparam int N_FILL = SLOTS;
  localparam int N_A1 = 100;
  localparam int N_A2 = 200;
  localparam int N_B2 = 200;
  localparam int N_TOTAL = 2 * N_FILL + N_A1 + N_A2 + N_B2;
  localparam int CYCLE_LIMIT = 2 * N_TOTAL * 3;

  logic                 clk;
  logic                 rst_n;
  logic                 a_req_valid_i;
  logic                 a_we_i;
  logic [`ADDR_W-1:0]   a_addr_i;
  logic [`DATA_W/8-1:0] a_be_i;
  logic [`DATA_W-1:0]   a_wdata_i;
  logic                 a_req_ready_o;
  logic                 a_rvalid_o;
  logic [`DATA_W-1:0]   a_rdata_o;
  logic                 b_req_valid_i;
  logic                 b_we_i;
  logic [`ADDR_W-1:0]   b_addr_i;
  logic [`DATA_W/8-1:0] b_be_i;
  logic [`DATA_W-1:0]   b_wdata_i;
  logic                 b_req_ready_o;
  logic                 b_rvalid_o;
  logic [`DATA_W-1:0]   b_rdata_o;

  // Reference model, one word array per port half
  logic [`DATA_W-1:0] model_a [SLOTS];
  logic [`DATA_W-1:0] model_b [SLOTS];
  integer seed = 32'hf0cca0e6;
  int     phase;
  int     cycle_cnt = 0;
  int     err_cnt;
  int     a_slot;
  int     b_slot;
  int     a_wait;
  int     b_wait;
  logic   a_hs;
  logic   b_hs;
  logic   a_rd_pend;
  logic   b_rd_pend;
  logic [`DATA_W-1:0] a_exp;
  logic [`DATA_W-1:0] b_exp;

  mem_subsys_top mem_subsys_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit derived from the request count
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failures found");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_value(string name, logic [`DATA_W-1:0] exp, logic [`DATA_W-1:0] act);
    err_cnt++;
    $display("FAIL %s expected %h actual %h", name, exp, act);
    $display("Test failures found");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_msg(string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "check failed");
  endtask

  // Byte-enabled update of a model word
  function automatic logic [`DATA_W-1:0] merge_bytes(logic [`DATA_W-1:0] old,
                                                     logic [`DATA_W-1:0] data,
                                                     logic [`DATA_W/8-1:0] be);
    logic [`DATA_W-1:0] res;
    res = old;
    for (int k = 0; k < `DATA_W/8; k++) begin
      if (be[k]) res[k*8 +: 8] = data[k*8 +: 8];
    end
    return res;
  endfunction

  // Random byte enables from the seeded stream
  function automatic logic [`DATA_W/8-1:0] random_be();
    int r;
    r = $random(seed);
    return r[`DATA_W/8-1:0];
  endfunction

  // Random direction bit
  function automatic logic random_bit();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // Port A slots 0..7 below the window, 8..15 inside it
  function automatic logic [`ADDR_W-1:0] a_addr_of(int slot);
    return (slot < 8) ? `ADDR_W'(slot * 32) : `ADDR_W'(`BUF_BASE + (slot - 8) * 32);
  endfunction

  // Port B slots in the upper half
  function automatic logic [`ADDR_W-1:0] b_addr_of(int slot);
    return `ADDR_W'(12'h800 + slot * 64);
  endfunction

  task automatic drive_a(logic we, int slot, logic [`DATA_W/8-1:0] be);
    a_req_valid_i = 1'b1;
    a_we_i        = we;
    a_slot        = slot;
    a_addr_i      = a_addr_of(slot);
    a_be_i        = be;
    a_wdata_i     = $random(seed);
  endtask

  task automatic drive_b(logic we, int slot, logic [`DATA_W/8-1:0] be);
    b_req_valid_i = 1'b1;
    b_we_i        = we;
    b_slot        = slot;
    b_addr_i      = b_addr_of(slot);
    b_be_i        = be;
    b_wdata_i     = $random(seed);
  endtask

  // Sampled mid-cycle where all DUT outputs are settled
  task automatic check_cycle();
    assert (a_rvalid_o == a_rd_pend)
      else fail_value("a_rvalid_o", `DATA_W'(a_rd_pend), `DATA_W'(a_rvalid_o));
    assert (b_rvalid_o == b_rd_pend)
      else fail_value("b_rvalid_o", `DATA_W'(b_rd_pend), `DATA_W'(b_rvalid_o));
    if (a_rd_pend) assert (a_rdata_o == a_exp) else fail_value("a_rdata_o", a_exp, a_rdata_o);
    if (b_rd_pend) assert (b_rdata_o == b_exp) else fail_value("b_rdata_o", b_exp, b_rdata_o);
    a_hs = a_req_valid_i && a_req_ready_o;
    b_hs = b_req_valid_i && b_req_ready_o;
    a_rd_pend = a_hs && !a_we_i;
    b_rd_pend = b_hs && !b_we_i;
    if (a_hs && a_we_i) model_a[a_slot] = merge_bytes(model_a[a_slot], a_wdata_i, a_be_i);
    if (a_rd_pend) a_exp = model_a[a_slot];
    if (b_hs && b_we_i) model_b[b_slot] = merge_bytes(model_b[b_slot], b_wdata_i, b_be_i);
    if (b_rd_pend) b_exp = model_b[b_slot];
    a_wait = (a_req_valid_i && !a_hs) ? a_wait + 1 : 0;
    b_wait = (b_req_valid_i && !b_hs) ? b_wait + 1 : 0;
    if (phase == 1 && a_req_valid_i) begin
      assert (a_req_ready_o) else fail_msg("Port A request stalled while port B was idle");
    end
    if (phase == 2) begin
      assert (a_wait <= 3) else fail_msg("Port A waited more than three cycles");
      assert (b_wait <= 2) else fail_msg("Port B waited more than two cycles");
    end
  endtask

  // One phase of traffic, ends when both ports are done and quiet
  task automatic run_phase(int n_a, int n_b);
    int a_left;
    int b_left;
    int kind;
    a_left = n_a;
    b_left = n_b;
    while (a_left > 0 || b_left > 0 || a_req_valid_i || b_req_valid_i || a_rd_pend ||
           b_rd_pend) begin
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #10;
      if (!a_req_valid_i || a_hs) begin
        a_req_valid_i = 1'b0;
        if (a_left > 0) begin
          kind = $unsigned($random(seed)) % 8;
          if (phase == 0) drive_a(1'b1, n_a - a_left, 4'hF);
          else if (phase == 1) drive_a(kind[0], $unsigned($random(seed)) % SLOTS, random_be());
          // Mostly posted writes into the window, mixed with reads
          else if (kind < 4) drive_a(1'b1, 8 + $unsigned($random(seed)) % 8, random_be());
          else if (kind == 4) drive_a(1'b1, $unsigned($random(seed)) % 8, random_be());
          else drive_a(1'b0, $unsigned($random(seed)) % SLOTS, 4'h0);
          a_left--;
        end
      end
      if (!b_req_valid_i || b_hs) begin
        b_req_valid_i = 1'b0;
        if (b_left > 0) begin
          if (phase == 0) drive_b(1'b1, n_b - b_left, 4'hF);
          else drive_b(random_bit(), $unsigned($random(seed)) % SLOTS, random_be());
          b_left--;
        end
      end
    end
  endtask

  // Quiet cycles so a held write can drain
  task automatic idle_cycles(int n);
    repeat (n) begin
      @(negedge clk);
      check_cycle();
    end
    @(posedge clk);
    #10;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    {a_req_valid_i, a_we_i, a_addr_i, a_be_i, a_wdata_i} = '0;
    {b_req_valid_i, b_we_i, b_addr_i, b_be_i, b_wdata_i} = '0;
    {a_hs, b_hs, a_rd_pend, b_rd_pend} = '0;
    {a_wait, b_wait, a_slot, b_slot, err_cnt} = '0;
    phase = 0;
    rst_n = 1'b0;
    // No response may appear while in reset
    repeat (4) begin
      @(negedge clk);
      assert (!a_rvalid_o && !b_rvalid_o) else fail_msg("Read valid seen during reset");
    end
    @(posedge clk);
    #10;
    rst_n = 1'b1;
    idle_cycles(2);
    run_phase(N_FILL, N_FILL);
    idle_cycles(3);
    phase = 1;
    run_phase(N_A1, 0);
    idle_cycles(3);
    phase = 2;
    run_phase(N_A2, N_B2);
    idle_cycles(3);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- tests/mem_subsys_props.sv
// Concurrent checks on the write buffer FSM and the arbiter
// Bound into write_buffer and bus_arbiter, unused inputs tied off

module mem_subsys_props import mem_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input wbuf_state_e wbuf_state,
  input logic        dn_ready,
  input logic        gnt_a,
  input logic        gnt_b,
  input logic        a_valid,
  input logic        b_valid,
  input logic        rd_xfer,
  input logic        a_rvalid,
  input logic        b_rvalid
);

  timeunit 1ns;
  timeprecision 1ps;

  // Held write stays until downstream takes it
  full_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (wbuf_state == WBUF_FULL && !dn_ready) |=> (wbuf_state == WBUF_FULL))
    else $error("write buffer left full state without downstream ready");

  // Response pulse only on the port whose read was taken one cycle earlier
  rsp_owner_a: assert property (@(posedge clk) disable iff (!rst_n)
    a_rvalid |-> $past(gnt_a && rd_xfer))
    else $error("read response on port A without a read from A");
  rsp_owner_b: assert property (@(posedge clk) disable iff (!rst_n)
    b_rvalid |-> $past(gnt_b && rd_xfer))
    else $error("read response on port B without a read from B");

  // Loser of a contested cycle is served next
  rr_turn_b: assert property (@(posedge clk) disable iff (!rst_n)
    (a_valid && b_valid && gnt_a && dn_ready) |=> (!b_valid || gnt_b))
    else $error("port B not served after losing arbitration");
  rr_turn_a: assert property (@(posedge clk) disable iff (!rst_n)
    (a_valid && b_valid && gnt_b && dn_ready) |=> (!a_valid || gnt_a))
    else $error("port A not served after losing arbitration");

endmodule

bind write_buffer mem_subsys_props wbuf_props_i (
  .clk(clk), .rst_n(rst_n), .wbuf_state(state_q), .dn_ready(dn.req_ready),
  .gnt_a(1'b0), .gnt_b(1'b0), .a_valid(1'b0), .b_valid(1'b0),
  .rd_xfer(1'b0), .a_rvalid(1'b0), .b_rvalid(1'b0)
);

bind bus_arbiter mem_subsys_props arb_props_i (
  .clk(clk), .rst_n(rst_n), .wbuf_state(mem_pkg::WBUF_EMPTY), .dn_ready(s.req_ready),
  .gnt_a(gnt_a), .gnt_b(gnt_b), .a_valid(m_a.req_valid), .b_valid(m_b.req_valid),
  .rd_xfer(xfer && !s.req.we), .a_rvalid(m_a.rsp_valid), .b_rvalid(m_b.rsp_valid)
);

//--- hdl/mem_subsys_top.sv
// Data-memory subsystem top level
// Port A goes through attribute lookup and write buffer, port B direct
// Both share the SRAM through the round-robin arbiter

`include "mem_cfg.svh"

module mem_subsys_top (
  input  logic                 clk,
  input  logic                 rst_n,
  // Port A, load/store data
  input  logic                 a_req_valid_i,
  input  logic                 a_we_i,
  input  logic [`ADDR_W-1:0]   a_addr_i,
  input  logic [`DATA_W/8-1:0] a_be_i,
  input  logic [`DATA_W-1:0]   a_wdata_i,
  output logic                 a_req_ready_o,
  output logic                 a_rvalid_o,
  output logic [`DATA_W-1:0]   a_rdata_o,
  // Port B, second master
  input  logic                 b_req_valid_i,
  input  logic                 b_we_i,
  input  logic [`ADDR_W-1:0]   b_addr_i,
  input  logic [`DATA_W/8-1:0] b_be_i,
  input  logic [`DATA_W-1:0]   b_wdata_i,
  output logic                 b_req_ready_o,
  output logic                 b_rvalid_o,
  output logic [`DATA_W-1:0]   b_rdata_o
);

  // Port A pins into the lookup
  mem_req_if a_port_if ();
  mem_req_if a_attr_if ();
  mem_req_if a_bus_if ();
  mem_req_if b_bus_if ();
  mem_req_if mem_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Pin packing
  ////////////////////////////////////////////////////////////////////////////

  // Attribute is filled in by the lookup
  assign a_port_if.req_valid = a_req_valid_i;
  assign a_port_if.req = '{addr: a_addr_i, we: a_we_i, be: a_be_i,
                           wdata: a_wdata_i, bufferable: 1'b0};
  assign a_req_ready_o = a_port_if.req_ready;
  assign a_rvalid_o    = a_port_if.rsp_valid;
  assign a_rdata_o     = a_port_if.rsp.rdata;

  // Port B is never posted
  assign b_bus_if.req_valid = b_req_valid_i;
  assign b_bus_if.req = '{addr: b_addr_i, we: b_we_i, be: b_be_i,
                          wdata: b_wdata_i, bufferable: 1'b0};
  assign b_req_ready_o = b_bus_if.req_ready;
  assign b_rvalid_o    = b_bus_if.rsp_valid;
  assign b_rdata_o     = b_bus_if.rsp.rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////////////////////

  mem_attr_lookup mem_attr_lookup_i (.up(a_port_if.slave), .dn(a_attr_if.master));

  write_buffer write_buffer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (a_attr_if.slave),
    .dn    (a_bus_if.master)
  );

  bus_arbiter bus_arbiter_i (
    .clk   (clk),
    .rst_n (rst_n),
    .m_a   (a_bus_if.slave),
    .m_b   (b_bus_if.slave),
    .s     (mem_if.master)
  );

  sram_slave sram_slave_i (.clk(clk), .rst_n(rst_n), .bus(mem_if.slave));

endmodule

//--- hdl/sram_slave.sv
// Word-addressed SRAM slave with byte enables
// Always ready, read data returned one cycle after acceptance

`include "mem_cfg.svh"

module sram_slave (
  input  logic     clk,
  input  logic     rst_n,
  mem_req_if.slave bus
);

  localparam int IDX_W = $clog2(`MEM_WORDS);

  logic [`DATA_W-1:0] mem_q [`MEM_WORDS];
  logic [`DATA_W-1:0] rdata_q;
  logic               rsp_valid_q;
  logic [IDX_W-1:0]   idx;
  logic               wr_en;
  logic               rd_en;

  // Never stalls
  assign bus.req_ready = 1'b1;

  // Drop the byte offset
  assign idx   = bus.req.addr[IDX_W+1:2];
  assign wr_en = bus.req_valid && bus.req_ready && bus.req.we;
  assign rd_en = bus.req_valid && bus.req_ready && !bus.req.we;

  ////////////////////////////////////////////////////////////////////////////
  // Array
  ////////////////////////////////////////////////////////////////////////////

  // Write lands at the acceptance edge
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < `DATA_W/8; i++) begin
        if (bus.req.be[i]) begin
          mem_q[idx][i*8 +: 8] <= bus.req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Registered read data
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rdata_q <= mem_q[idx];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      // One pulse per accepted read
      rsp_valid_q <= rd_en;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp.rdata = rdata_q;

endmodule

//--- hdl/bus_arbiter.sv
// Round-robin arbiter of two masters onto one slave
// Tracks the owner of each read and routes the response pulse back

module bus_arbiter (
  input  logic      clk,
  input  logic      rst_n,
  mem_req_if.slave  m_a,
  mem_req_if.slave  m_b,
  mem_req_if.master s
);

  logic prio_b_q;
  logic rd_owner_b_q;
  logic gnt_a;
  logic gnt_b;
  logic xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Grant
  ////////////////////////////////////////////////////////////////////////////

  // A wins when alone or when it holds priority
  assign gnt_a = m_a.req_valid && (!m_b.req_valid || !prio_b_q);
  // B takes whatever A does not
  assign gnt_b = m_b.req_valid && !gnt_a;

  // Accepted beat on the slave side
  assign xfer = s.req_valid && s.req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Priority and read owner
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Port A first out of reset
      prio_b_q <= 1'b0;
    end else if (xfer) begin
      // Hand priority to the port that was not just served
      prio_b_q <= gnt_a;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_owner_b_q <= 1'b0;
    end else if (xfer && !s.req.we) begin
      // Only needed for the cycle after the read
      rd_owner_b_q <= gnt_b;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Request mux
  ////////////////////////////////////////////////////////////////////////////

  assign s.req_valid = gnt_a || gnt_b;
  assign s.req       = gnt_a ? m_a.req : m_b.req;

  // Slave ready reaches only the granted port
  assign m_a.req_ready = gnt_a && s.req_ready;
  assign m_b.req_ready = gnt_b && s.req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Response routing
  ////////////////////////////////////////////////////////////////////////////

  // Pulse goes to the owner only, data is shared
  assign m_a.rsp_valid = s.rsp_valid && !rd_owner_b_q;
  assign m_b.rsp_valid = s.rsp_valid && rd_owner_b_q;
  assign m_a.rsp       = s.rsp;
  assign m_b.rsp       = s.rsp;

endmodule

//--- hdl/write_buffer.sv
// Single-entry write buffer for the load/store port
// Two-state FSM with one held request register

module write_buffer import mem_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  mem_req_if.slave  up,
  mem_req_if.master dn
);

  wbuf_state_e state_q;
  wbuf_state_e state_d;
  mem_req_t    held_q;
  logic        push;
  logic        bufferable;

  // Attribute from the lookup stage
  assign bufferable = up.req.bufferable;

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= WBUF_EMPTY;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    push    = 1'b0;
    case (state_q)
      WBUF_EMPTY: begin
        // Posted write blocked downstream, take it anyway
        if (up.req_valid && bufferable && !dn.req_ready) begin
          state_d = WBUF_FULL;
          push    = 1'b1;
        end
      end
      WBUF_FULL: begin
        // Held write drains this cycle
        if (dn.req_ready) begin
          if (up.req_valid && bufferable) begin
            // Refill in the same cycle
            push = 1'b1;
          end else begin
            state_d = WBUF_EMPTY;
          end
        end
      end
      default: begin
        state_d = WBUF_EMPTY;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Held request
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      held_q <= up.req;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////////////////////

  // When full the held write goes first, else pass-through
  assign dn.req_valid = (state_q == WBUF_FULL) || up.req_valid;
  assign dn.req       = (state_q == WBUF_FULL) ? held_q : up.req;

  // Full buffer frees a slot only for another posted write
  assign up.req_ready = (state_q == WBUF_FULL) ? (bufferable && dn.req_ready)
                                               : (bufferable || dn.req_ready);

  // Buffered writes produce no response, so reads map one to one
  assign up.rsp_valid = dn.rsp_valid;
  assign up.rsp       = dn.rsp;

endmodule

//--- hdl/mem_attr_lookup.sv
// Memory attribute lookup for port A
// Marks writes into the configured window as bufferable

`include "mem_cfg.svh"

module mem_attr_lookup (
  mem_req_if.slave  up,
  mem_req_if.master dn
);

  logic in_window;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  // Inclusive window check on the byte address
  assign in_window = (up.req.addr >= `BUF_BASE) &&
                     (up.req.addr <= `BUF_LIMIT);

  ////////////////////////////////////////////////////////////////////////////
  // Request path
  ////////////////////////////////////////////////////////////////////////////

  assign dn.req_valid = up.req_valid;

  always_comb begin
    // Copy all fields, then overwrite the attribute
    dn.req            = up.req;
    // Only writes can be posted, reads always go out in order
    dn.req.bufferable = up.req.we && in_window;
  end

  // Handshake back-pressure is passed straight up
  assign up.req_ready = dn.req_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Response path
  ////////////////////////////////////////////////////////////////////////////

  // Read responses are untouched
  assign up.rsp_valid = dn.rsp_valid;
  assign up.rsp       = dn.rsp;

endmodule

//--- hdl/mem_req_if.sv
// Valid/ready request channel with a one-cycle read response pulse
// Master and slave modports

interface mem_req_if import mem_pkg::*; ();

  // Request direction
  logic     req_valid;
  logic     req_ready;
  mem_req_t req;

  // Response direction, single-cycle pulse one cycle after a read
  logic     rsp_valid;
  mem_rsp_t rsp;

  // Initiator side
  modport master (
    output req_valid,
    output req,
    input  req_ready,
    input  rsp_valid,
    input  rsp
  );

  // Target side
  modport slave (
    input  req_valid,
    input  req,
    output req_ready,
    output rsp_valid,
    output rsp
  );

endinterface

//--- hdl/mem_pkg.sv
// Request and response structs of the memory bus
// State encoding of the write buffer FSM

package mem_pkg;

  `include "mem_cfg.svh"

  // One request beat as seen on every channel
  typedef struct packed {
    logic [`ADDR_W-1:0]   addr;
    logic                 we;
    logic [`DATA_W/8-1:0] be;
    logic [`DATA_W-1:0]   wdata;
    // Set by the attribute lookup, ignored by the SRAM
    logic                 bufferable;
  } mem_req_t;

  // Read response payload
  typedef struct packed {
    logic [`DATA_W-1:0] rdata;
  } mem_rsp_t;

  // Write buffer occupancy
  typedef enum logic {
    WBUF_EMPTY,
    WBUF_FULL
  } wbuf_state_e;

endpackage

//--- hdl/mem_cfg.svh
// Bus widths and SRAM depth of the data-memory subsystem
// Address window that is marked bufferable for port A writes

`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus geometry
////////////////////////////////////////////////////////////////////////////

// Byte address width
`define ADDR_W 12
// Data word width
`define DATA_W 32

// SRAM depth in words, covers the full byte address range
`define MEM_WORDS 1024

////////////////////////////////////////////////////////////////////////////
// Bufferable window
////////////////////////////////////////////////////////////////////////////

// Inclusive byte bounds, inside the lower (port A) half
`define BUF_BASE 12'h200
`define BUF_LIMIT 12'h3FF

`endif
